// File: corr_pkg.sv
package corr_pkg;

    // input format, per real or imaginary part
    localparam int din_width_c = 16;
    localparam int din_point_c = 14;

    // format of the cast products that enter the accumulators
    localparam int acc_width_c = 20;
    localparam int acc_point_c = 16;

    // running sum width, sized for the frame counts in use
    localparam int dout_width_c = 32;

    // payload of the r12 accumulators
    typedef logic signed [acc_width_c-1:0] acc_signed_t;

    // payload of the power accumulators
    typedef logic [acc_width_c-1:0] acc_unsigned_t;

endpackage

// File: corr_mults.sv
`timescale 1ns/1ps

module corr_mults
    import corr_pkg::*;
#(
    parameter int DIN_WIDTH = din_width_c
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic signed [DIN_WIDTH-1:0] din1_re,
    input  logic signed [DIN_WIDTH-1:0] din1_im,
    input  logic signed [DIN_WIDTH-1:0] din2_re,
    input  logic signed [DIN_WIDTH-1:0] din2_im,
    input  logic                        din_valid,
    input  logic                        frame_start,
    output logic [2*DIN_WIDTH:0]        pow1,
    output logic [2*DIN_WIDTH:0]        pow2,
    output logic signed [2*DIN_WIDTH:0] cross_re,
    output logic signed [2*DIN_WIDTH:0] cross_im,
    output logic                        prod_valid,
    output logic                        prod_start
);

    localparam int PROD_W = 2 * DIN_WIDTH;
    localparam int SUM_W = 2 * DIN_WIDTH + 1;

    // registered inputs
    logic signed [DIN_WIDTH-1:0] re1_q, im1_q, re2_q, im2_q;

    // squares for the powers
    logic signed [PROD_W-1:0] sq_re1, sq_im1, sq_re2, sq_im2;

    // partial products for ch1 * conj(ch2)
    logic signed [PROD_W-1:0] p_rr, p_ii, p_ir, p_ri;

    // valid and start follow the data, one bit per stage
    logic [2:0] valid_sr;
    logic [2:0] start_sr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr <= '0;
            start_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[1:0], din_valid};
            start_sr <= {start_sr[1:0], frame_start};
        end
    end

    always_ff @(posedge clk) begin
        re1_q <= din1_re;
        im1_q <= din1_im;
        re2_q <= din2_re;
        im2_q <= din2_im;

        sq_re1 <= PROD_W'(re1_q) * PROD_W'(re1_q);
        sq_im1 <= PROD_W'(im1_q) * PROD_W'(im1_q);
        sq_re2 <= PROD_W'(re2_q) * PROD_W'(re2_q);
        sq_im2 <= PROD_W'(im2_q) * PROD_W'(im2_q);
        p_rr   <= PROD_W'(re1_q) * PROD_W'(re2_q);
        p_ii   <= PROD_W'(im1_q) * PROD_W'(im2_q);
        p_ir   <= PROD_W'(im1_q) * PROD_W'(re2_q);
        p_ri   <= PROD_W'(re1_q) * PROD_W'(im2_q);

        // squares are never negative, so they extend with a zero
        pow1     <= {1'b0, sq_re1} + {1'b0, sq_im1};
        pow2     <= {1'b0, sq_re2} + {1'b0, sq_im2};
        cross_re <= SUM_W'(p_rr) + SUM_W'(p_ii);
        cross_im <= SUM_W'(p_ir) - SUM_W'(p_ri);
    end

    assign prod_valid = valid_sr[2];
    assign prod_start = start_sr[2];

    a_start_in_valid: assert property (@(posedge clk) disable iff (!rst_n)
        prod_start |-> prod_valid)
        else $error("corr_mults: prod_start without prod_valid");

endmodule

// File: fixed_cast.sv
`timescale 1ns/1ps

module fixed_cast
    import corr_pkg::*;
#(
    parameter int IN_WIDTH = 2 * din_width_c + 1,
    parameter int IN_POINT = 2 * din_point_c,
    parameter int ACC_WIDTH = acc_width_c,
    parameter int ACC_POINT = acc_point_c
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [IN_WIDTH-1:0]        pow1,
    input  logic [IN_WIDTH-1:0]        pow2,
    input  logic signed [IN_WIDTH-1:0] cross_re,
    input  logic signed [IN_WIDTH-1:0] cross_im,
    input  logic                       prod_valid,
    input  logic                       prod_start,
    output acc_unsigned_t              cast_pow1,
    output acc_unsigned_t              cast_pow2,
    output acc_signed_t                cast_re,
    output acc_signed_t                cast_im,
    output logic                       cast_valid,
    output logic                       cast_start
);

    // dropping fractional bits is a floor for both signed and unsigned
    localparam int SHIFT = IN_POINT - ACC_POINT;
    localparam int SH_W = IN_WIDTH - SHIFT;

    function automatic acc_unsigned_t sat_u(input logic [IN_WIDTH-1:0] v);
        logic [SH_W-1:0] s;
        s = v[IN_WIDTH-1:SHIFT];
        if (|s[SH_W-1:ACC_WIDTH])
            return '1;
        return s[ACC_WIDTH-1:0];
    endfunction

    function automatic acc_signed_t sat_s(input logic signed [IN_WIDTH-1:0] v);
        logic [SH_W-1:0] s;
        logic [SH_W-ACC_WIDTH:0] top;
        s = v[IN_WIDTH-1:SHIFT];
        // fits when every bit above the acc sign bit matches it
        top = s[SH_W-1:ACC_WIDTH-1];
        if (&top || ~|top)
            return s[ACC_WIDTH-1:0];
        if (s[SH_W-1])
            return {1'b1, {(ACC_WIDTH-1){1'b0}}};
        return {1'b0, {(ACC_WIDTH-1){1'b1}}};
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cast_valid <= 1'b0;
            cast_start <= 1'b0;
        end else begin
            cast_valid <= prod_valid;
            cast_start <= prod_valid & prod_start;
        end
    end

    always_ff @(posedge clk) begin
        cast_pow1 <= sat_u(pow1);
        cast_pow2 <= sat_u(pow2);
        cast_re   <= sat_s(cross_re);
        cast_im   <= sat_s(cross_im);
    end

    a_sat_bound: assert property (@(posedge clk) disable iff (!rst_n)
        cast_valid |-> (IN_WIDTH'(cast_pow1) <= ($past(pow1) >> SHIFT))
                    && (IN_WIDTH'(cast_pow2) <= ($past(pow2) >> SHIFT)))
        else $error("fixed_cast: unsigned cast above its shifted input");

endmodule

// File: vector_acc.sv
`timescale 1ns/1ps

module vector_acc
    import corr_pkg::*;
#(
    parameter type sample_t = acc_signed_t,
    parameter int VECTOR_LEN = 64,
    parameter int DOUT_WIDTH = dout_width_c
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sample_t               din,
    input  logic                  din_valid,
    input  logic                  new_acc,
    output logic [DOUT_WIDTH-1:0] dout,
    output logic                  dout_valid
);

    localparam int AW = (VECTOR_LEN > 1) ? $clog2(VECTOR_LEN) : 1;

    logic [DOUT_WIDTH-1:0] sum_ram [VECTOR_LEN];

    logic [AW-1:0] bin_cnt;
    // new_acc of the frame in progress, and whether it flushes a finished period
    logic          first_frame;
    logic          emit_frame;
    logic          have_data;
    logic          cur_first;
    logic          cur_emit;

    // read stage
    sample_t               din_q;
    logic [AW-1:0]         addr_q;
    logic                  valid_q;
    logic                  first_q;
    logic                  emit_q;
    logic [DOUT_WIDTH-1:0] rd_q;

    logic [DOUT_WIDTH-1:0] din_ext;
    logic [DOUT_WIDTH-1:0] new_sum;

    assign cur_first = (bin_cnt == '0) ? new_acc : first_frame;
    assign cur_emit  = (bin_cnt == '0) ? (new_acc & have_data) : emit_frame;

    // the size cast extends by the signedness of sample_t
    assign din_ext = DOUT_WIDTH'(din_q);
    assign new_sum = first_q ? din_ext : rd_q + din_ext;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bin_cnt     <= '0;
            first_frame <= 1'b0;
            emit_frame  <= 1'b0;
            have_data   <= 1'b0;
        end else if (din_valid) begin
            first_frame <= cur_first;
            emit_frame  <= cur_emit;
            if (cur_first)
                have_data <= 1'b1;
            if (bin_cnt == AW'(VECTOR_LEN - 1))
                bin_cnt <= '0;
            else
                bin_cnt <= bin_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            first_q    <= 1'b0;
            emit_q     <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            valid_q    <= din_valid;
            first_q    <= cur_first;
            emit_q     <= cur_emit;
            dout_valid <= valid_q & emit_q;
        end
    end

    always_ff @(posedge clk) begin
        din_q  <= din;
        addr_q <= bin_cnt;
        // bypass the sum that is written to the same bin in this cycle
        if (valid_q && din_valid && addr_q == bin_cnt)
            rd_q <= new_sum;
        else
            rd_q <= sum_ram[bin_cnt];
    end

    // write back, and hand out the finished sum of the old period
    always_ff @(posedge clk) begin
        if (valid_q)
            sum_ram[addr_q] <= new_sum;
        dout <= rd_q;
    end

    a_acc_on_bin0: assert property (@(posedge clk) disable iff (!rst_n)
        (din_valid && new_acc) |-> (bin_cnt == '0))
        else $error("vector_acc: new_acc away from bin 0");

endmodule

// File: correlation_matrix.sv
`timescale 1ns/1ps

module correlation_matrix
    import corr_pkg::*;
#(
    parameter int DIN_WIDTH = din_width_c,
    parameter int DIN_POINT = din_point_c,
    parameter int ACC_WIDTH = acc_width_c,
    parameter int ACC_POINT = acc_point_c,
    parameter int DOUT_WIDTH = dout_width_c,
    parameter int VECTOR_LEN = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        frame_start,
    input  logic signed [DIN_WIDTH-1:0] din1_re,
    input  logic signed [DIN_WIDTH-1:0] din1_im,
    input  logic signed [DIN_WIDTH-1:0] din2_re,
    input  logic signed [DIN_WIDTH-1:0] din2_im,
    input  logic                        din_valid,
    output logic [DOUT_WIDTH-1:0]       r11,
    output logic [DOUT_WIDTH-1:0]       r22,
    output logic [DOUT_WIDTH-1:0]       r12_re,
    output logic [DOUT_WIDTH-1:0]       r12_im,
    output logic                        dout_valid
);

    localparam int PROD_W = 2 * DIN_WIDTH + 1;

    // full-precision products
    logic [PROD_W-1:0]        pow1, pow2;
    logic signed [PROD_W-1:0] cross_re, cross_im;
    logic                     prod_valid, prod_start;

    // products in accumulator format
    acc_unsigned_t cast_pow1, cast_pow2;
    acc_signed_t   cast_re, cast_im;
    logic          cast_valid, cast_start;

    corr_mults #(
        .DIN_WIDTH(DIN_WIDTH)
    ) mults_i (
        .clk(clk),
        .rst_n(rst_n),
        .din1_re(din1_re),
        .din1_im(din1_im),
        .din2_re(din2_re),
        .din2_im(din2_im),
        .din_valid(din_valid),
        .frame_start(frame_start),
        .pow1(pow1),
        .pow2(pow2),
        .cross_re(cross_re),
        .cross_im(cross_im),
        .prod_valid(prod_valid),
        .prod_start(prod_start)
    );

    fixed_cast #(
        .IN_WIDTH(PROD_W),
        .IN_POINT(2 * DIN_POINT),
        .ACC_WIDTH(ACC_WIDTH),
        .ACC_POINT(ACC_POINT)
    ) cast_i (
        .clk(clk),
        .rst_n(rst_n),
        .pow1(pow1),
        .pow2(pow2),
        .cross_re(cross_re),
        .cross_im(cross_im),
        .prod_valid(prod_valid),
        .prod_start(prod_start),
        .cast_pow1(cast_pow1),
        .cast_pow2(cast_pow2),
        .cast_re(cast_re),
        .cast_im(cast_im),
        .cast_valid(cast_valid),
        .cast_start(cast_start)
    );

    // powers accumulate unsigned, the cross terms signed
    vector_acc #(
        .sample_t(acc_unsigned_t),
        .VECTOR_LEN(VECTOR_LEN),
        .DOUT_WIDTH(DOUT_WIDTH)
    ) r11_acc_i (
        .clk(clk),
        .rst_n(rst_n),
        .din(cast_pow1),
        .din_valid(cast_valid),
        .new_acc(cast_start),
        .dout(r11),
        .dout_valid()
    );

    vector_acc #(
        .sample_t(acc_unsigned_t),
        .VECTOR_LEN(VECTOR_LEN),
        .DOUT_WIDTH(DOUT_WIDTH)
    ) r22_acc_i (
        .clk(clk),
        .rst_n(rst_n),
        .din(cast_pow2),
        .din_valid(cast_valid),
        .new_acc(cast_start),
        .dout(r22),
        .dout_valid()
    );

    vector_acc #(
        .sample_t(acc_signed_t),
        .VECTOR_LEN(VECTOR_LEN),
        .DOUT_WIDTH(DOUT_WIDTH)
    ) r12_re_acc_i (
        .clk(clk),
        .rst_n(rst_n),
        .din(cast_re),
        .din_valid(cast_valid),
        .new_acc(cast_start),
        .dout(r12_re),
        .dout_valid(dout_valid)
    );

    vector_acc #(
        .sample_t(acc_signed_t),
        .VECTOR_LEN(VECTOR_LEN),
        .DOUT_WIDTH(DOUT_WIDTH)
    ) r12_im_acc_i (
        .clk(clk),
        .rst_n(rst_n),
        .din(cast_im),
        .din_valid(cast_valid),
        .new_acc(cast_start),
        .dout(r12_im),
        .dout_valid()
    );

endmodule

// File: tb_correlation_matrix.sv
`timescale 1ns/1ps

module tb_correlation_matrix
    import corr_pkg::*;
;

    localparam int vec_len_c = 8;
    localparam int shift_c = 2 * din_point_c - acc_point_c;
    // 35 frames at most, each sample with up to two idle cycles before it
    localparam int max_frames_c = 35;
    localparam int max_cycles_c = 8 + 20 + max_frames_c * vec_len_c * 3;

    typedef struct packed {
        logic [dout_width_c-1:0] r11;
        logic [dout_width_c-1:0] r22;
        logic [dout_width_c-1:0] re;
        logic [dout_width_c-1:0] im;
        longint                  due;
    } expect_t;

    logic clk;
    logic rst_n;
    logic frame_start;
    logic din_valid;
    logic signed [din_width_c-1:0] din1_re, din1_im, din2_re, din2_im;
    logic [dout_width_c-1:0] r11, r22, r12_re, r12_im;
    logic dout_valid;

    // reference model state
    expect_t exp_q[$];
    logic [dout_width_c-1:0] sum_r11 [vec_len_c];
    logic [dout_width_c-1:0] sum_r22 [vec_len_c];
    logic [dout_width_c-1:0] sum_re [vec_len_c];
    logic [dout_width_c-1:0] sum_im [vec_len_c];
    int bin_m = 0;
    logic first_m = 1'b0;
    logic emit_m = 1'b0;
    logic have_data_m = 1'b0;
    longint cyc = 0;
    logic [31:0] lcg_state = 32'd72;

    // captured outputs, compared one cycle later
    logic chk_en = 1'b0;
    logic chk_empty = 1'b0;
    expect_t chk_exp;
    logic [dout_width_c-1:0] act_r11, act_r22, act_re, act_im;
    longint act_cyc;

    correlation_matrix #(
        .VECTOR_LEN(vec_len_c)
    ) dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .frame_start(frame_start),
        .din1_re(din1_re),
        .din1_im(din1_im),
        .din2_re(din2_re),
        .din2_im(din2_im),
        .din_valid(din_valid),
        .r11(r11),
        .r22(r22),
        .r12_re(r12_re),
        .r12_im(r12_im),
        .dout_valid(dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input longint expected, input longint actual);
        $display("ERR t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // floor shift, then clamp to the unsigned acc range
    function automatic longint cast_unsigned(input longint p);
        longint v;
        longint top;
        v = p >>> shift_c;
        top = (longint'(1) << acc_width_c) - 1;
        if (v > top)
            return top;
        return v;
    endfunction

    function automatic longint cast_signed(input longint p);
        longint v;
        longint hi;
        v = p >>> shift_c;
        hi = (longint'(1) << (acc_width_c - 1)) - 1;
        if (v > hi)
            return hi;
        if (v < -hi - 1)
            return -hi - 1;
        return v;
    endfunction

    task automatic idle_cycle();
        logic [31:0] r;
        r = next_rand();
        din_valid = 1'b0;
        frame_start = 1'b0;
        // data is don't care without valid
        din1_re = r[31:16];
        din2_im = r[15:0];
        @(posedge clk);
        #1;
    endtask

    task automatic drive_sample(input logic signed [15:0] a_re, input logic signed [15:0] a_im,
                                input logic signed [15:0] b_re, input logic signed [15:0] b_im,
                                input logic start);
        longint c11;
        longint c22;
        longint cre;
        longint cim;
        expect_t e;
        din1_re = a_re;
        din1_im = a_im;
        din2_re = b_re;
        din2_im = b_im;
        din_valid = 1'b1;
        frame_start = start;
        if (bin_m == 0) begin
            first_m = start;
            emit_m = start && have_data_m;
            if (start)
                have_data_m = 1'b1;
        end
        c11 = cast_unsigned(longint'(a_re) * a_re + longint'(a_im) * a_im);
        c22 = cast_unsigned(longint'(b_re) * b_re + longint'(b_im) * b_im);
        cre = cast_signed(longint'(a_re) * b_re + longint'(a_im) * b_im);
        cim = cast_signed(longint'(a_im) * b_re - longint'(a_re) * b_im);
        // the finished sum of the old period leaves 6 cycles after this input
        if (emit_m) begin
            e.r11 = sum_r11[bin_m];
            e.r22 = sum_r22[bin_m];
            e.re = sum_re[bin_m];
            e.im = sum_im[bin_m];
            e.due = cyc + 6;
            exp_q.push_back(e);
        end
        if (first_m) begin
            sum_r11[bin_m] = dout_width_c'(c11);
            sum_r22[bin_m] = dout_width_c'(c22);
            sum_re[bin_m] = dout_width_c'(cre);
            sum_im[bin_m] = dout_width_c'(cim);
        end else begin
            sum_r11[bin_m] = sum_r11[bin_m] + dout_width_c'(c11);
            sum_r22[bin_m] = sum_r22[bin_m] + dout_width_c'(c22);
            sum_re[bin_m] = sum_re[bin_m] + dout_width_c'(cre);
            sum_im[bin_m] = sum_im[bin_m] + dout_width_c'(cim);
        end
        bin_m = (bin_m + 1) % vec_len_c;
        @(posedge clk);
        #1;
        din_valid = 1'b0;
        frame_start = 1'b0;
    endtask

    // mode 0 random, 1 full scale, 2 random with gaps
    task automatic send_frame(input logic start, input int mode);
        logic signed [15:0] v [4];
        logic [31:0] r;
        for (int b = 0; b < vec_len_c; b++) begin
            if (mode == 2) begin
                r = next_rand();
                repeat (r[25:24] % 3) idle_cycle();
            end
            for (int i = 0; i < 4; i++) begin
                r = next_rand();
                // bin 0 is all most-negative, which drives cross_re past its limit
                if (mode == 1)
                    v[i] = (r[20] && b != 0) ? 16'sh7fff : 16'sh8000;
                else
                    v[i] = r[31:16];
            end
            drive_sample(v[0], v[1], v[2], v[3], start && (b == 0));
        end
    endtask

    task automatic send_period(input int nframes, input int mode);
        send_frame(1'b1, mode);
        repeat (nframes - 1) send_frame(1'b0, mode);
    endtask

    always @(posedge clk) begin
        chk_en <= dout_valid;
        chk_empty <= 1'b0;
        act_r11 <= r11;
        act_r22 <= r22;
        act_re <= r12_re;
        act_im <= r12_im;
        act_cyc <= cyc;
        if (dout_valid) begin
            if (exp_q.size() == 0)
                chk_empty <= 1'b1;
            else
                chk_exp <= exp_q.pop_front();
        end
    end

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        chk_en |-> !chk_empty)
        else report_failure("dout_valid went high while no output was expected");

    a_due: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && !chk_empty) |-> (act_cyc == chk_exp.due))
        else report_value("dout_valid cycle", chk_exp.due, act_cyc);

    a_r11: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && !chk_empty) |-> (act_r11 == chk_exp.r11))
        else report_value("r11", chk_exp.r11, act_r11);

    a_r22: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && !chk_empty) |-> (act_r22 == chk_exp.r22))
        else report_value("r22", chk_exp.r22, act_r22);

    a_r12_re: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && !chk_empty) |-> (act_re == chk_exp.re))
        else report_value("r12_re", chk_exp.re, act_re);

    a_r12_im: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_en && !chk_empty) |-> (act_im == chk_exp.im))
        else report_value("r12_im", chk_exp.im, act_im);

    initial begin
        #((max_cycles_c + 100) * 8);
        report_failure("watchdog expired before the test sequence finished");
    end

    initial begin
        logic [31:0] r;
        rst_n = 1'b0;
        frame_start = 1'b0;
        din_valid = 1'b0;
        din1_re = '0;
        din1_im = '0;
        din2_re = '0;
        din2_im = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) idle_cycle();
        // first period only fills the sums
        send_period(1, 0);
        repeat (4) idle_cycle();
        send_period(1, 0);
        send_period(3, 0);
        // full scale pushes the cross terms into saturation
        send_period(3, 1);
        send_period(2, 2);
        for (int p = 0; p < 6; p++) begin
            r = next_rand();
            send_period(1 + r[17:16], r[20] ? 2 : 0);
        end
        // flush the last period
        send_frame(1'b1, 0);
        repeat (10) idle_cycle();
        if (exp_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            report_failure("expected outputs never appeared on dout_valid");
        end
    end

endmodule

// File: filelist.f
corr_pkg.sv
corr_mults.sv
fixed_cast.sv
vector_acc.sv
correlation_matrix.sv
tb_correlation_matrix.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the correlation matrix testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_correlation_matrix \
    -f filelist.f \
    -o sim_tb

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_tb | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
